// ==== all.f ====
hw/snd_fmt_pkg.sv
hw/snd_cfg_pkg.sv
hw/dac_cen_gen.sv
hw/sd_dac_chan.sv
hw/pcm_condition.sv
hw/snd_cfg_regs.sv
hw/snd_dac_top.sv
tests/snd_dac_assertions.sv
tests/snd_dac_tb.sv

// ==== hw/dac_cen_gen.sv ====
// Clock enable for the sigma-delta modulators
// One-hot ring, one pulse every CEN_DIV cycles

`timescale 1ns/1ps
`default_nettype none

module dac_cen_gen #(
    parameter int CEN_DIV = 4
) (
    input  wire  clk_dac,
    input  wire  rst,
    output logic cen_o
);

    // Token starts on the top bit so the first pulse is delayed
    localparam logic [CEN_DIV-1:0] RING_RST = {1'b1, {(CEN_DIV-1){1'b0}}};

    logic [CEN_DIV-1:0] ring;

    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            ring <= RING_RST;
        end else begin
            // Rotate towards the MSB, wrap into bit 0
            ring <= {ring[CEN_DIV-2:0], ring[CEN_DIV-1]};
        end
    end

    assign cen_o = ring[0];

endmodule

`default_nettype wire

// ==== hw/pcm_condition.sv ====
// Sample conditioning ahead of the modulators
// Capture on enable, mute, sign flip, padding and mono copy

`timescale 1ns/1ps
`default_nettype none

module pcm_condition (
    input  wire                    clk_dac,
    input  wire                    rst,
    input  wire                    cen_i,
    input  snd_fmt_pkg::pcm_pair_t snd_i,
    input  snd_cfg_pkg::snd_ctrl_t ctrl_i,
    output snd_fmt_pkg::dac_word_t word_l_o,
    output snd_fmt_pkg::dac_word_t word_r_o
);

    // Mute, offset binary conversion and padding of one sample
    function automatic snd_fmt_pkg::dac_word_t pad_sample(
        input snd_fmt_pkg::pcm_sample_t snd,
        input logic                     mute,
        input logic                     signed_in
    );
        snd_fmt_pkg::pcm_sample_t u;
        begin
            u = mute ? '0 : {snd[15] ^ signed_in, snd[14:0]};
            // Zero headroom bit halves full scale
            pad_sample = {1'b0, u, 3'd0};
        end
    endfunction

    snd_fmt_pkg::dac_word_t cond_l;
    snd_fmt_pkg::dac_word_t cond_r;

    assign cond_l = pad_sample(snd_i.left, ctrl_i.mute_l, ctrl_i.signed_in);
    assign cond_r = pad_sample(snd_i.right, ctrl_i.mute_r, ctrl_i.signed_in);

    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            word_l_o <= '0;
            word_r_o <= '0;
        end else if (cen_i) begin
            word_l_o <= cond_l;
            // Right channel follows the left word in mono
            word_r_o <= ctrl_i.stereo ? cond_r : cond_l;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sd_dac_chan.sv ====
// First-order sigma-delta modulator, one channel
// Accumulator carry is the 1-bit output

`timescale 1ns/1ps
`default_nettype none

module sd_dac_chan (
    input  wire                    clk_dac,
    input  wire                    rst,
    input  wire                    cen_i,
    input  snd_fmt_pkg::dac_word_t word_i,
    output logic                   bit_o
);

    localparam int W = snd_fmt_pkg::PAD_W;

    // Residue of previous updates, fed back on each enable
    logic [W-1:0] acc;
    logic [W:0]   sum;

    // Extra bit on top catches the carry
    assign sum = {1'b0, acc} + {1'b0, word_i};

    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            acc   <= '0;
            bit_o <= 1'b0;
        end else if (cen_i) begin
            acc   <= sum[W-1:0];
            bit_o <= sum[W];
        end
    end

    // Average density of bit_o is word_i / 2**W since the error stays in acc

endmodule

`default_nettype wire

// ==== hw/snd_cfg_pkg.sv ====
// Configuration register map and control types
// Control fields and host write port

`default_nettype none

package snd_cfg_pkg;

    localparam int CFG_ADDR_W = 2;

    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [7:0]            cfg_data_t;

    // Only register in the map
    localparam cfg_addr_t REG_CTRL = 2'd0;

    // signed_in lands on data bit 0, mute_r on bit 3
    typedef struct packed {
        logic mute_r;
        logic mute_l;
        logic stereo;
        logic signed_in;
    } snd_ctrl_t;

    typedef struct packed {
        logic      we;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_wr_t;

endpackage

`default_nettype wire

// ==== hw/snd_cfg_regs.sv ====
// Sound configuration registers
// Control register write decode, readback and reset defaults

`timescale 1ns/1ps
`default_nettype none

module snd_cfg_regs #(
    parameter bit SIGNED_RST = 1'b0
) (
    input  wire                    clk_dac,
    input  wire                    rst,
    input  snd_cfg_pkg::cfg_wr_t   cfg_wr_i,
    output snd_cfg_pkg::cfg_data_t cfg_rdata_o,
    output snd_cfg_pkg::snd_ctrl_t ctrl_o
);

    // Mono with both channels audible
    localparam snd_cfg_pkg::snd_ctrl_t CTRL_RST = '{
        mute_r:    1'b0,
        mute_l:    1'b0,
        stereo:    1'b0,
        signed_in: SIGNED_RST
    };

    logic ctrl_hit;

    assign ctrl_hit = cfg_wr_i.addr == snd_cfg_pkg::REG_CTRL;

    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            ctrl_o <= CTRL_RST;
        end else if (cfg_wr_i.we && ctrl_hit) begin
            ctrl_o <= snd_cfg_pkg::snd_ctrl_t'(cfg_wr_i.data[3:0]);
        end
    end

    // Readback follows the address on the write port
    always_comb begin
        if (ctrl_hit) begin
            cfg_rdata_o = {4'd0, ctrl_o};
        end else begin
            // Unused addresses read as zero
            cfg_rdata_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snd_dac_top.sv ====
// Stereo 1-bit sound output block
// Registers, enable generator, conditioning and two modulators

`timescale 1ns/1ps
`default_nettype none

module snd_dac_top #(
    parameter int CEN_DIV    = 4,
    parameter bit SIGNED_RST = 1'b0
) (
    input  wire                    clk_dac,
    input  wire                    rst,
    input  snd_cfg_pkg::cfg_wr_t   cfg_wr_i,
    output snd_cfg_pkg::cfg_data_t cfg_rdata_o,
    input  snd_fmt_pkg::pcm_pair_t snd_i,
    output logic                   snd_pwm_left_o,
    output logic                   snd_pwm_right_o
);

    snd_cfg_pkg::snd_ctrl_t ctrl;
    logic                   cen;
    snd_fmt_pkg::dac_word_t word_l;
    snd_fmt_pkg::dac_word_t word_r;

    snd_cfg_regs #(
        .SIGNED_RST ( SIGNED_RST )
    ) u_cfg_regs (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .cfg_wr_i    ( cfg_wr_i    ),
        .cfg_rdata_o ( cfg_rdata_o ),
        .ctrl_o      ( ctrl        )
    );

    dac_cen_gen #(
        .CEN_DIV ( CEN_DIV )
    ) u_cen_gen (
        .clk_dac ( clk_dac ),
        .rst     ( rst     ),
        .cen_o   ( cen     )
    );

    pcm_condition u_condition (
        .clk_dac  ( clk_dac ),
        .rst      ( rst     ),
        .cen_i    ( cen     ),
        .snd_i    ( snd_i   ),
        .ctrl_i   ( ctrl    ),
        .word_l_o ( word_l  ),
        .word_r_o ( word_r  )
    );

    // Right word already carries the mono copy
    sd_dac_chan u_chan_l (
        .clk_dac ( clk_dac        ),
        .rst     ( rst            ),
        .cen_i   ( cen            ),
        .word_i  ( word_l         ),
        .bit_o   ( snd_pwm_left_o )
    );

    sd_dac_chan u_chan_r (
        .clk_dac ( clk_dac         ),
        .rst     ( rst             ),
        .cen_i   ( cen             ),
        .word_i  ( word_r          ),
        .bit_o   ( snd_pwm_right_o )
    );

endmodule

`default_nettype wire

// ==== hw/snd_fmt_pkg.sv ====
// Sample formats for the sound output path
// PCM sample, stereo pair and padded modulator word

`default_nettype none

package snd_fmt_pkg;

    // Raw PCM sample with signedness set by configuration
    typedef logic [15:0] pcm_sample_t;

    // Stereo pair as delivered by the sound generator
    typedef struct packed {
        pcm_sample_t left;
        pcm_sample_t right;
    } pcm_pair_t;

    // Modulator word width
    localparam int PAD_W = 20;

    // Offset binary word: headroom bit, sample, three low zeros
    typedef logic [PAD_W-1:0] dac_word_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the sound DAC testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module snd_dac_tb -Mdir obj_dir -f all.f
out=$(./obj_dir/Vsnd_dac_tb || true)
echo "$out"
if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

// ==== tests/snd_dac_assertions.sv ====
// Concurrent checks on the enable and the modulator outputs
// Bound into sd_dac_chan and dac_cen_gen

`timescale 1ns/1ps
`default_nettype none

module snd_dac_assertions #(
    parameter bit CHECK_BIT = 1'b1
) (
    input wire clk_dac,
    input wire rst,
    input wire cen_i,
    input wire bit_i
);

    // Enable is a single-cycle pulse
    cen_single: assert property (
        @(posedge clk_dac) disable iff (rst) cen_i |=> !cen_i
    ) else $error("enable high on two consecutive cycles");

    if (CHECK_BIT) begin : g_bit_checks
        // Output moves only right after an enable
        bit_after_cen: assert property (
            @(posedge clk_dac) disable iff (rst) !$stable(bit_i) |-> $past(cen_i)
        ) else $error("modulator bit changed without a preceding enable");

        bit_low_in_rst: assert property (
            @(posedge clk_dac) rst |-> !bit_i
        ) else $error("modulator bit high during reset");
    end

endmodule

bind sd_dac_chan snd_dac_assertions u_chan_checks (
    .clk_dac ( clk_dac ),
    .rst     ( rst     ),
    .cen_i   ( cen_i   ),
    .bit_i   ( bit_o   )
);

// Enable generator has no output bit of its own
bind dac_cen_gen snd_dac_assertions #(
    .CHECK_BIT ( 1'b0 )
) u_cen_checks (
    .clk_dac ( clk_dac ),
    .rst     ( rst     ),
    .cen_i   ( cen_o   ),
    .bit_i   ( 1'b0    )
);

`default_nettype wire

// ==== tests/snd_dac_tb.sv ====
// Testbench for the stereo sigma-delta sound output
// Stimulus table, pin density counting, register checks, watchdog

`timescale 1ns/1ps
`default_nettype none

module snd_dac_tb;

    localparam int CEN_DIV    = 4;
    localparam int NUM_TC     = 8;
    localparam int WIN_CEN    = 1024;
    localparam int SETTLE_CYC = 8 * CEN_DIV;
    localparam int WIN_CYC    = WIN_CEN * CEN_DIV;
    localparam int TOL_CYC    = 2 * CEN_DIV;
    localparam int TIMEOUT_NS = (NUM_TC * (1032 * CEN_DIV + 10) + 16) * 10 * 2;

    logic                   clk_dac;
    logic                   rst;
    snd_cfg_pkg::cfg_wr_t   cfg_wr;
    snd_cfg_pkg::cfg_data_t cfg_rdata;
    snd_fmt_pkg::pcm_pair_t snd;
    logic                   pwm_l;
    logic                   pwm_r;

    // Stimulus table columns, expected counts derive from them
    string                    tc_name  [NUM_TC];
    snd_fmt_pkg::pcm_sample_t tc_left  [NUM_TC];
    snd_fmt_pkg::pcm_sample_t tc_right [NUM_TC];
    snd_cfg_pkg::snd_ctrl_t   tc_ctrl  [NUM_TC];

    integer seed;
    int     err_ctrl;
    int     err_rdata;
    int     err_count;
    int     err_pin;

    snd_dac_top uut (
        .clk_dac         ( clk_dac   ),
        .rst             ( rst       ),
        .cfg_wr_i        ( cfg_wr    ),
        .cfg_rdata_o     ( cfg_rdata ),
        .snd_i           ( snd       ),
        .snd_pwm_left_o  ( pwm_l     ),
        .snd_pwm_right_o ( pwm_r     )
    );

    initial begin
        clk_dac = 1'b0;
        forever #5 clk_dac = ~clk_dac;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns before the test table completed", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_ctrl(input string name, input snd_cfg_pkg::snd_ctrl_t exp,
                              input snd_cfg_pkg::snd_ctrl_t act);
        if (act !== exp) begin
            $display("ERR %s: ctrl expected %b, actual %b", name, exp, act);
            err_ctrl++;
        end
    endtask

    task automatic check_rdata(input string name, input snd_cfg_pkg::cfg_data_t exp,
                               input snd_cfg_pkg::cfg_data_t act);
        if (act !== exp) begin
            $display("ERR %s: rdata expected %h, actual %h", name, exp, act);
            err_rdata++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act < exp - TOL_CYC || act > exp + TOL_CYC) begin
            $display("ERR %s: count expected %0d (+/-%0d), actual %0d", name, exp, TOL_CYC, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: pin expected %b, actual %b", name, exp, act);
            err_pin++;
        end
    endtask

    // One-cycle strobe starting on a falling edge
    task automatic write_cfg(input snd_cfg_pkg::cfg_addr_t addr,
                             input snd_cfg_pkg::cfg_data_t data);
        cfg_wr.we   = 1'b1;
        cfg_wr.addr = addr;
        cfg_wr.data = data;
        @(negedge clk_dac);
        cfg_wr.we = 1'b0;
    endtask

    task automatic read_cfg(input snd_cfg_pkg::cfg_addr_t addr,
                            output snd_cfg_pkg::cfg_data_t data);
        cfg_wr.we   = 1'b0;
        cfg_wr.addr = addr;
        @(negedge clk_dac);
        data = cfg_rdata;
    endtask

    // High cycles per pin over the window at u/2^17 ones per enable
    function automatic int expected_cycles(input snd_fmt_pkg::pcm_sample_t smp,
                                           input logic mute, input logic signed_in);
        int u;
        u = int'(smp);
        if (signed_in) begin
            u = u ^ 'h8000;
        end
        if (mute) begin
            u = 0;
        end
        return CEN_DIV * ((WIN_CEN * u) / (1 << 17));
    endfunction

    task automatic count_window(output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (WIN_CYC) begin
            @(negedge clk_dac);
            if (pwm_l) ones_l++;
            if (pwm_r) ones_r++;
        end
    endtask

    // Control bits are {mute_r, mute_l, stereo, signed_in}
    task automatic load_table();
        logic [31:0] rnd;
        tc_name[0]  = "uns_zero_full";
        tc_left[0]  = 16'h0000;
        tc_right[0] = 16'hFFFF;
        tc_ctrl[0]  = 4'b0010;
        tc_name[1]  = "uns_mid";
        tc_left[1]  = 16'h4000;
        tc_right[1] = 16'hC000;
        tc_ctrl[1]  = 4'b0010;
        tc_name[2]  = "signed_mid";
        tc_left[2]  = 16'h0000;
        tc_right[2] = 16'h8000;
        tc_ctrl[2]  = 4'b0011;
        tc_name[3]  = "mono_copy";
        tc_left[3]  = 16'h6000;
        tc_right[3] = 16'h1234;
        tc_ctrl[3]  = 4'b0000;
        tc_name[4]  = "mute_left";
        tc_left[4]  = 16'hA000;
        tc_right[4] = 16'h3000;
        tc_ctrl[4]  = 4'b0110;
        tc_name[5]  = "mute_right";
        tc_left[5]  = 16'h2000;
        tc_right[5] = 16'hE000;
        tc_ctrl[5]  = 4'b1010;
        for (int i = 6; i < NUM_TC; i++) begin
            rnd = $random(seed);
            tc_left[i]  = rnd[15:0];
            tc_right[i] = rnd[31:16];
        end
        tc_name[6] = "rand_stereo";
        tc_ctrl[6] = 4'b0010;
        tc_name[7] = "rand_signed";
        tc_ctrl[7] = 4'b0011;
    endtask

    initial begin : main_seq
        snd_cfg_pkg::cfg_data_t rdata;
        snd_cfg_pkg::snd_ctrl_t ctrl;
        int                     ones_l;
        int                     ones_r;
        int                     exp_l;
        int                     exp_r;
        rst       = 1'b0;
        cfg_wr    = '0;
        snd       = '0;
        seed      = 32'h12d90acb;
        err_ctrl  = 0;
        err_rdata = 0;
        err_count = 0;
        err_pin   = 0;
        load_table();
        #1;
        rst = 1'b1;
        repeat (16) @(negedge clk_dac);
        rst = 1'b0;

        // Reset defaults are unsigned, mono and no mutes
        check_bit("reset left pin", 1'b0, pwm_l);
        check_bit("reset right pin", 1'b0, pwm_r);
        read_cfg(snd_cfg_pkg::REG_CTRL, rdata);
        check_ctrl("reset ctrl", 4'b0000, snd_cfg_pkg::snd_ctrl_t'(rdata[3:0]));
        check_rdata("reset rdata", 8'h00, rdata);

        // Upper data bits are not stored
        write_cfg(snd_cfg_pkg::REG_CTRL, 8'hFD);
        read_cfg(snd_cfg_pkg::REG_CTRL, rdata);
        check_ctrl("reg write", 4'b1101, snd_cfg_pkg::snd_ctrl_t'(rdata[3:0]));
        check_rdata("reg write", 8'h0D, rdata);
        write_cfg(2'd1, 8'hFF);
        read_cfg(snd_cfg_pkg::REG_CTRL, rdata);
        check_rdata("unused write", 8'h0D, rdata);
        read_cfg(2'd1, rdata);
        check_rdata("unused read 1", 8'h00, rdata);
        read_cfg(2'd3, rdata);
        check_rdata("unused read 3", 8'h00, rdata);

        for (int i = 0; i < NUM_TC; i++) begin
            write_cfg(snd_cfg_pkg::REG_CTRL, {4'd0, tc_ctrl[i]});
            read_cfg(snd_cfg_pkg::REG_CTRL, rdata);
            check_ctrl(tc_name[i], tc_ctrl[i], snd_cfg_pkg::snd_ctrl_t'(rdata[3:0]));
            check_rdata(tc_name[i], {4'd0, tc_ctrl[i]}, rdata);
            snd.left  = tc_left[i];
            snd.right = tc_right[i];
            repeat (SETTLE_CYC) @(negedge clk_dac);
            count_window(ones_l, ones_r);
            ctrl  = tc_ctrl[i];
            exp_l = expected_cycles(tc_left[i], ctrl.mute_l, ctrl.signed_in);
            if (ctrl.stereo) begin
                exp_r = expected_cycles(tc_right[i], ctrl.mute_r, ctrl.signed_in);
            end else begin
                // Right pin follows the left stream in mono
                exp_r = exp_l;
            end
            check_count({tc_name[i], " left"}, exp_l, ones_l);
            check_count({tc_name[i], " right"}, exp_r, ones_r);
        end

        $display("Error counts: ctrl %0d, rdata %0d, count %0d, pin %0d",
                 err_ctrl, err_rdata, err_count, err_pin);
        if (err_ctrl + err_rdata + err_count + err_pin == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
